// ==== hw/kitchen_pkg.sv ====
package kitchen_pkg;

    typedef enum logic [1:0] {
        left,
        right,
        up,
        down
    } direction_e;

    typedef enum logic [2:0] {
        welcome,
        start,
        play,
        pause,
        finish
    } game_state_e;

    typedef enum logic [3:0] {
        obj_empty,
        obj_onion_whole,
        obj_onion_chopped,
        obj_bowl_empty,
        obj_bowl_full,
        obj_pot_empty,
        obj_pot_raw,
        obj_pot_cooked,
        obj_pot_fire,
        obj_fire,
        obj_extinguisher
    } grid_obj_e;

    // what a player is doing or carrying
    typedef enum logic [3:0] {
        p_nothing,
        p_chopping,
        p_onion_whole,
        p_onion_chopped,
        p_pot_empty,
        p_pot_raw,
        p_pot_cooked,
        p_bowl_empty,
        p_bowl_full,
        p_ext_off,
        p_ext_on
    } player_state_e;

    typedef enum logic [1:0] {
        pot_idle,
        pot_raw,
        pot_cooked,
        pot_fire
    } pot_state_e;

    localparam int grid_cols   = 13;
    localparam int grid_rows   = 8;
    localparam int tile_px     = 32;
    localparam int tile_offset = 16;   // rounds to the nearest tile

    typedef logic [3:0] col_t;
    typedef logic [2:0] row_t;
    typedef logic [8:0] pixel_t;
    typedef logic [3:0] timer_t;
    typedef grid_obj_e [grid_rows-1:0][grid_cols-1:0] object_grid_t;

    localparam int frames_per_tick = 60;
    localparam int chop_time       = 5;
    localparam int cook_time       = 10;
    localparam int burn_time       = 5;

    // station cells
    localparam int pantry_col   = 0;
    localparam int pantry_row_a = 2;
    localparam int pantry_row_b = 3;
    localparam int bowl_col     = 12;
    localparam int bowl_row     = 6;
    localparam int ext_col      = 0;
    localparam int ext_row      = 6;
    localparam int board_row    = 7;
    localparam int board_col_a  = 2;
    localparam int board_col_b  = 4;
    localparam int pot_row      = 0;
    localparam int pot_col_a    = 8;
    localparam int pot_col_b    = 10;

    typedef struct packed {
        logic      valid;
        col_t      col;
        row_t      row;
        grid_obj_e obj;
    } grid_write_t;

    localparam int num_writers = 6;   // players 0-1, boards, pots

endpackage

// ==== hw/player_if.sv ====
interface player_if;

    logic [3:0] cell_x;
    logic [2:0] cell_y;
    logic [3:0] front_x;
    logic [2:0] front_y;
    logic [1:0] direction;
    logic [3:0] state;
    logic [3:0] old_state;        // state one frame back
    logic [3:0] object_in_front;

    modport locator (
        output cell_x, cell_y, front_x, front_y,
        output direction, state, old_state, object_in_front
    );

    modport observer (
        input cell_x, cell_y, front_x, front_y,
        input direction, state, old_state, object_in_front
    );

endinterface

// ==== hw/player_locator.sv ====
module player_locator (
    input  logic                       vsync,
    input  logic                       reset,
    input  kitchen_pkg::pixel_t        x,
    input  kitchen_pkg::pixel_t        y,
    input  kitchen_pkg::direction_e    direction,
    input  kitchen_pkg::player_state_e state,
    input  kitchen_pkg::object_grid_t  object_grid,
    player_if.locator                  player
);

    logic [9:0] sum_x, sum_y;     // headroom for the rounding offset
    logic [4:0] col_raw, row_raw;
    kitchen_pkg::col_t cell_x, front_x;
    kitchen_pkg::row_t cell_y, front_y;
    kitchen_pkg::player_state_e old_state;

    always_comb begin
        sum_x   = 10'(x) + 10'(kitchen_pkg::tile_offset);
        sum_y   = 10'(y) + 10'(kitchen_pkg::tile_offset);
        col_raw = 5'(sum_x / kitchen_pkg::tile_px);
        row_raw = 5'(sum_y / kitchen_pkg::tile_px);
        // keep off-screen positions inside the grid
        cell_x = (col_raw > 5'(kitchen_pkg::grid_cols - 1)) ?
                 kitchen_pkg::col_t'(kitchen_pkg::grid_cols - 1) : col_raw[3:0];
        cell_y = (row_raw > 5'(kitchen_pkg::grid_rows - 1)) ?
                 kitchen_pkg::row_t'(kitchen_pkg::grid_rows - 1) : row_raw[2:0];

        front_x = cell_x;
        front_y = cell_y;
        case (direction)
            kitchen_pkg::left:  if (cell_x != 0) front_x = cell_x - 1'b1;
            kitchen_pkg::right: if (cell_x != kitchen_pkg::grid_cols - 1) front_x = cell_x + 1'b1;
            kitchen_pkg::up:    if (cell_y != 0) front_y = cell_y - 1'b1;
            default:            if (cell_y != kitchen_pkg::grid_rows - 1) front_y = cell_y + 1'b1;
        endcase
    end

    always_ff @(posedge vsync) begin
        if (reset) begin
            old_state <= kitchen_pkg::p_nothing;
        end else begin
            old_state <= state;
        end
    end

    assign player.cell_x          = cell_x;
    assign player.cell_y          = cell_y;
    assign player.front_x         = front_x;
    assign player.front_y         = front_y;
    assign player.direction       = direction;
    assign player.state           = state;
    assign player.old_state       = old_state;
    assign player.object_in_front = object_grid[front_y][front_x];

endmodule

// ==== hw/player_rules.sv ====
module player_rules (
    input  logic                     playing,
    player_if.observer               player,
    output kitchen_pkg::grid_write_t request
);

    kitchen_pkg::player_state_e state, old_state;
    kitchen_pkg::grid_obj_e     front_obj;
    logic                       refill_cell;

    always_comb begin
        state     = kitchen_pkg::player_state_e'(player.state);
        old_state = kitchen_pkg::player_state_e'(player.old_state);
        front_obj = kitchen_pkg::grid_obj_e'(player.object_in_front);
        // pantry and bowl stack never run out
        refill_cell = (player.front_x == kitchen_pkg::pantry_col &&
                       (player.front_y == kitchen_pkg::pantry_row_a ||
                        player.front_y == kitchen_pkg::pantry_row_b)) ||
                      (player.front_x == kitchen_pkg::bowl_col &&
                       player.front_y == kitchen_pkg::bowl_row);

        request.valid = 1'b0;
        request.col   = player.front_x;
        request.row   = player.front_y;
        request.obj   = kitchen_pkg::obj_empty;

        if (playing) begin
            if (state == kitchen_pkg::p_ext_on) begin
                if (front_obj == kitchen_pkg::obj_fire) begin
                    request.valid = 1'b1;
                    request.obj   = kitchen_pkg::obj_pot_empty;
                end
            end else if (state == kitchen_pkg::p_nothing) begin
                // put-down of whatever was held
                request.valid = 1'b1;
                case (old_state)
                    kitchen_pkg::p_onion_whole: request.obj = kitchen_pkg::obj_onion_whole;
                    kitchen_pkg::p_onion_chopped: begin
                        if (front_obj == kitchen_pkg::obj_pot_empty)
                            request.obj = kitchen_pkg::obj_pot_raw;
                        else if (front_obj == kitchen_pkg::obj_empty)
                            request.obj = kitchen_pkg::obj_onion_chopped;
                        else
                            request.valid = 1'b0;
                    end
                    kitchen_pkg::p_pot_empty: begin
                        if (front_obj == kitchen_pkg::obj_onion_chopped)
                            request.obj = kitchen_pkg::obj_pot_raw;
                        else if (front_obj == kitchen_pkg::obj_empty)
                            request.obj = kitchen_pkg::obj_pot_empty;
                        else
                            request.valid = 1'b0;
                    end
                    kitchen_pkg::p_pot_raw:    request.obj = kitchen_pkg::obj_pot_raw;
                    kitchen_pkg::p_pot_cooked: request.obj = kitchen_pkg::obj_pot_cooked;
                    kitchen_pkg::p_bowl_empty: request.obj = kitchen_pkg::obj_bowl_empty;
                    kitchen_pkg::p_bowl_full:  request.obj = kitchen_pkg::obj_bowl_full;
                    kitchen_pkg::p_ext_off:    request.obj = kitchen_pkg::obj_extinguisher;
                    default:                   request.valid = 1'b0;
                endcase
            end else if (old_state == kitchen_pkg::p_nothing) begin
                if (state != kitchen_pkg::p_chopping) begin
                    request.valid = 1'b1;
                    request.obj   = refill_cell ? front_obj : kitchen_pkg::obj_empty;
                end
            end else if (old_state == kitchen_pkg::p_pot_cooked &&
                         state == kitchen_pkg::p_pot_empty) begin
                request.valid = 1'b1;   // ladle into the bowl in front
                request.obj   = kitchen_pkg::obj_bowl_full;
            end else if (old_state == kitchen_pkg::p_bowl_empty &&
                         state == kitchen_pkg::p_bowl_full) begin
                request.valid = 1'b1;
                request.obj   = kitchen_pkg::obj_pot_empty;
            end
        end
    end

endmodule

// ==== hw/countdown_timer.sv ====
module countdown_timer #(
    parameter int start_value = 5
) (
    input  logic                vsync,
    input  logic                reset,
    input  logic                go,
    input  logic                restart,
    output kitchen_pkg::timer_t time_left
);

    logic [$clog2(kitchen_pkg::frames_per_tick)-1:0] frame_cnt;

    always_ff @(posedge vsync) begin
        if (reset || restart) begin
            time_left <= kitchen_pkg::timer_t'(start_value);
            frame_cnt <= '0;
        end else if (go && time_left != 0) begin
            if (frame_cnt == kitchen_pkg::frames_per_tick - 1) begin
                frame_cnt <= '0;
                time_left <= time_left - 1'b1;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hw/chop_station.sv ====
module chop_station #(
    parameter int board_col = 2
) (
    input  logic                     vsync,
    input  logic                     reset,
    input  logic                     playing,
    player_if.observer               players [2],
    input  kitchen_pkg::grid_obj_e   board_obj,
    output kitchen_pkg::timer_t      time_left,
    output kitchen_pkg::grid_write_t request
);

    logic [1:0] chopping, started;
    logic       has_onion, go, restart, done;

    // chopping means standing just above the board, facing down
    for (genvar i = 0; i < 2; i++) begin : g_player
        assign chopping[i] = players[i].state == kitchen_pkg::p_chopping &&
                             players[i].cell_x == board_col &&
                             players[i].cell_y == kitchen_pkg::board_row - 1 &&
                             players[i].direction == kitchen_pkg::down;
        assign started[i]  = chopping[i] && players[i].old_state != kitchen_pkg::p_chopping;
    end

    assign has_onion = board_obj == kitchen_pkg::obj_onion_whole;
    assign done      = playing && has_onion && time_left == 0;
    assign go        = playing && has_onion && |chopping;
    assign restart   = (playing && |started) || done;

    countdown_timer #(
        .start_value(kitchen_pkg::chop_time)
    ) u_chop_timer (
        .vsync    (vsync),
        .reset    (reset),
        .go       (go),
        .restart  (restart),
        .time_left(time_left)
    );

    assign request.valid = done;
    assign request.col   = kitchen_pkg::col_t'(board_col);
    assign request.row   = kitchen_pkg::row_t'(kitchen_pkg::board_row);
    assign request.obj   = kitchen_pkg::obj_onion_chopped;

endmodule

// ==== hw/pot_station.sv ====
module pot_station #(
    parameter int pot_col = 8
) (
    input  logic                     vsync,
    input  logic                     reset,
    input  logic                     playing,
    input  kitchen_pkg::grid_obj_e   pot_obj,
    output kitchen_pkg::timer_t      time_left,
    output kitchen_pkg::grid_write_t request
);

    kitchen_pkg::pot_state_e state, next_state;
    kitchen_pkg::timer_t     burn_left;
    logic                    cook_go, burn_go, idle;

    assign idle    = state == kitchen_pkg::pot_idle;   // both countdowns held full
    assign cook_go = playing && state == kitchen_pkg::pot_raw;
    assign burn_go = playing && state == kitchen_pkg::pot_cooked;

    countdown_timer #(.start_value(kitchen_pkg::cook_time)) u_cook_timer (
        .vsync(vsync), .reset(reset), .go(cook_go), .restart(playing && idle),
        .time_left(time_left)
    );

    countdown_timer #(.start_value(kitchen_pkg::burn_time)) u_burn_timer (
        .vsync(vsync), .reset(reset), .go(burn_go), .restart(playing && idle),
        .time_left(burn_left)
    );

    always_comb begin
        next_state    = state;
        request.valid = 1'b0;
        request.col   = kitchen_pkg::col_t'(pot_col);
        request.row   = kitchen_pkg::row_t'(kitchen_pkg::pot_row);
        request.obj   = kitchen_pkg::obj_pot_cooked;
        case (state)
            kitchen_pkg::pot_idle:
                if (pot_obj == kitchen_pkg::obj_pot_raw) next_state = kitchen_pkg::pot_raw;
            kitchen_pkg::pot_raw: begin
                if (pot_obj == kitchen_pkg::obj_empty) begin
                    next_state = kitchen_pkg::pot_idle;
                end else if (time_left == 0) begin
                    next_state    = kitchen_pkg::pot_cooked;
                    request.valid = playing;
                end
            end
            kitchen_pkg::pot_cooked: begin
                // taken off the stove before it burns
                if (pot_obj != kitchen_pkg::obj_pot_cooked) begin
                    next_state = kitchen_pkg::pot_idle;
                end else if (burn_left == 0) begin
                    next_state    = kitchen_pkg::pot_fire;
                    request.valid = playing;
                    request.obj   = kitchen_pkg::obj_fire;
                end
            end
            default:
                if (pot_obj != kitchen_pkg::obj_fire) next_state = kitchen_pkg::pot_idle;
        endcase
    end

    always_ff @(posedge vsync) begin
        if (reset) begin
            state <= kitchen_pkg::pot_idle;
        end else if (playing) begin
            state <= next_state;
        end
    end

endmodule

// ==== hw/kitchen_grid.sv ====
module kitchen_grid (
    input  logic                      vsync,
    input  logic                      reset,
    input  kitchen_pkg::grid_write_t  requests [kitchen_pkg::num_writers],
    output kitchen_pkg::object_grid_t object_grid
);

    always_ff @(posedge vsync) begin
        if (reset) begin
            for (int r = 0; r < kitchen_pkg::grid_rows; r++) begin
                for (int c = 0; c < kitchen_pkg::grid_cols; c++) begin
                    object_grid[r][c] <= kitchen_pkg::obj_empty;
                end
            end
            object_grid[kitchen_pkg::pantry_row_a][kitchen_pkg::pantry_col] <=
                kitchen_pkg::obj_onion_whole;
            object_grid[kitchen_pkg::pantry_row_b][kitchen_pkg::pantry_col] <=
                kitchen_pkg::obj_onion_whole;
            object_grid[kitchen_pkg::bowl_row][kitchen_pkg::bowl_col] <=
                kitchen_pkg::obj_bowl_empty;
            object_grid[kitchen_pkg::pot_row][kitchen_pkg::pot_col_a] <= kitchen_pkg::obj_pot_empty;
            object_grid[kitchen_pkg::pot_row][kitchen_pkg::pot_col_b] <= kitchen_pkg::obj_pot_empty;
            object_grid[kitchen_pkg::ext_row][kitchen_pkg::ext_col] <=
                kitchen_pkg::obj_extinguisher;
        end else begin
            // later writers overwrite earlier ones on the same cell
            for (int i = 0; i < kitchen_pkg::num_writers; i++) begin
                if (requests[i].valid) begin
                    object_grid[requests[i].row][requests[i].col] <= requests[i].obj;
                end
            end
        end
    end

endmodule

// ==== hw/kitchen_action.sv ====
module kitchen_action (
    input  logic                       vsync,
    input  logic                       reset,
    input  kitchen_pkg::game_state_e   game_state,
    input  kitchen_pkg::pixel_t        player0_x,
    input  kitchen_pkg::pixel_t        player0_y,
    input  kitchen_pkg::pixel_t        player1_x,
    input  kitchen_pkg::pixel_t        player1_y,
    input  kitchen_pkg::direction_e    player0_direction,
    input  kitchen_pkg::direction_e    player1_direction,
    input  kitchen_pkg::player_state_e player0_state,
    input  kitchen_pkg::player_state_e player1_state,
    output kitchen_pkg::object_grid_t  object_grid,
    output kitchen_pkg::timer_t [3:0]  time_grid   // [3] board 2 .. [0] pot 10
);

    logic                     playing;
    kitchen_pkg::grid_write_t requests [kitchen_pkg::num_writers];

    assign playing = game_state == kitchen_pkg::play;

    player_if players [2] ();

    player_locator u_locator0 (
        .vsync(vsync), .reset(reset), .x(player0_x), .y(player0_y),
        .direction(player0_direction), .state(player0_state),
        .object_grid(object_grid), .player(players[0])
    );

    player_locator u_locator1 (
        .vsync(vsync), .reset(reset), .x(player1_x), .y(player1_y),
        .direction(player1_direction), .state(player1_state),
        .object_grid(object_grid), .player(players[1])
    );

    player_rules u_rules0 (.playing(playing), .player(players[0]), .request(requests[0]));
    player_rules u_rules1 (.playing(playing), .player(players[1]), .request(requests[1]));

    chop_station #(.board_col(kitchen_pkg::board_col_a)) u_board_a (
        .vsync(vsync), .reset(reset), .playing(playing), .players(players),
        .board_obj(object_grid[kitchen_pkg::board_row][kitchen_pkg::board_col_a]),
        .time_left(time_grid[3]), .request(requests[2])
    );

    chop_station #(.board_col(kitchen_pkg::board_col_b)) u_board_b (
        .vsync(vsync), .reset(reset), .playing(playing), .players(players),
        .board_obj(object_grid[kitchen_pkg::board_row][kitchen_pkg::board_col_b]),
        .time_left(time_grid[2]), .request(requests[3])
    );

    pot_station #(.pot_col(kitchen_pkg::pot_col_a)) u_pot_a (
        .vsync(vsync), .reset(reset), .playing(playing),
        .pot_obj(object_grid[kitchen_pkg::pot_row][kitchen_pkg::pot_col_a]),
        .time_left(time_grid[1]), .request(requests[4])
    );

    pot_station #(.pot_col(kitchen_pkg::pot_col_b)) u_pot_b (
        .vsync(vsync), .reset(reset), .playing(playing),
        .pot_obj(object_grid[kitchen_pkg::pot_row][kitchen_pkg::pot_col_b]),
        .time_left(time_grid[0]), .request(requests[5])
    );

    kitchen_grid u_grid (
        .vsync      (vsync),
        .reset      (reset),
        .requests   (requests),
        .object_grid(object_grid)
    );

endmodule

// ==== test/tb_tasks.svh ====
// rising vsync then the small drive delay
task automatic next_frame();
    @(posedge vsync);
    #2;
endtask

// random spot inside the tile so only the rounding picks the cell
task automatic place_player(input int id, input int col, input int row,
                            input kitchen_pkg::direction_e dir);
    int px;
    int py;
    px = kitchen_pkg::tile_px * col - kitchen_pkg::tile_offset
         + int'($urandom % kitchen_pkg::tile_px);
    py = kitchen_pkg::tile_px * row - kitchen_pkg::tile_offset
         + int'($urandom % kitchen_pkg::tile_px);
    if (px < 0) px = 0;
    if (py < 0) py = 0;
    if (id == 0) begin
        player0_x         = kitchen_pkg::pixel_t'(px);
        player0_y         = kitchen_pkg::pixel_t'(py);
        player0_direction = dir;
    end else begin
        player1_x         = kitchen_pkg::pixel_t'(px);
        player1_y         = kitchen_pkg::pixel_t'(py);
        player1_direction = dir;
    end
endtask

task automatic wait_for_cell(input int col, input int row,
                             input kitchen_pkg::grid_obj_e expected, input int limit);
    int frames;
    frames = 0;
    while (object_grid[row][col] != expected && frames < limit) begin
        next_frame();
        frames++;
    end
    if (object_grid[row][col] != expected) begin
        $display("Timeout in %s: cell (%0d,%0d) did not become %s within %0d frames",
                 cur_test, col, row, expected.name(), limit);
        test_errors++;
    end
endtask

task automatic wait_for_timer_below(input int idx, input int bound, input int limit);
    int frames;
    frames = 0;
    while (time_grid[idx] >= bound && frames < limit) begin
        next_frame();
        frames++;
    end
    if (time_grid[idx] >= bound) begin
        $display("Timeout in %s: timer %0d stayed at %0d or more for %0d frames",
                 cur_test, idx, bound, limit);
        test_errors++;
    end
endtask

task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    tests_run++;
endtask

task automatic finish_test();
    $display("%s finished: %0d errors", cur_test, test_errors);
    total_errors += test_errors;
endtask

// ==== test/tb_kitchen_action.sv ====
module tb_kitchen_action;
    timeunit 1ns;
    timeprecision 1ps;

    logic                       vsync;
    logic                       reset;
    kitchen_pkg::game_state_e   game_state;
    kitchen_pkg::pixel_t        player0_x, player0_y, player1_x, player1_y;
    kitchen_pkg::direction_e    player0_direction, player1_direction;
    kitchen_pkg::player_state_e player0_state, player1_state;
    kitchen_pkg::object_grid_t  object_grid;
    kitchen_pkg::timer_t [3:0]  time_grid;   // [3] board 2, [2] board 4, [1] pot 8, [0] pot 10

    string                      cur_test = "reset";
    int                         test_errors = 0;
    int                         total_errors = 0;
    int                         tests_run = 0;
    int                         checks = 0;

    `include "tb_tasks.svh"

    kitchen_action u_kitchen_action (
        .vsync            (vsync),
        .reset            (reset),
        .game_state       (game_state),
        .player0_x        (player0_x),
        .player0_y        (player0_y),
        .player1_x        (player1_x),
        .player1_y        (player1_y),
        .player0_direction(player0_direction),
        .player1_direction(player1_direction),
        .player0_state    (player0_state),
        .player1_state    (player1_state),
        .object_grid      (object_grid),
        .time_grid        (time_grid)
    );

    always #20 vsync = ~vsync;

    // start layout of the kitchen
    function automatic kitchen_pkg::grid_obj_e layout_at(input int col, input int row);
        if (col == 0 && (row == 2 || row == 3)) return kitchen_pkg::obj_onion_whole;
        if (col == 12 && row == 6) return kitchen_pkg::obj_bowl_empty;
        if (row == 0 && (col == 8 || col == 10)) return kitchen_pkg::obj_pot_empty;
        if (col == 0 && row == 6) return kitchen_pkg::obj_extinguisher;
        return kitchen_pkg::obj_empty;
    endfunction

    task automatic check_cell(input int col, input int row,
                              input kitchen_pkg::grid_obj_e expected);
        kitchen_pkg::grid_obj_e actual;
        actual = object_grid[row][col];
        checks++;
        assert (actual == expected) else begin
            $display("Fail %s: cell (%0d,%0d) expected %s, actual %s",
                     cur_test, col, row, expected.name(), actual.name());
            test_errors++;
        end
    endtask

    task automatic check_timer(input int idx, input int expected);
        int actual;
        actual = int'(time_grid[idx]);
        checks++;
        assert (actual == expected) else begin
            $display("Fail %s: timer %0d expected %0d, actual %0d",
                     cur_test, idx, expected, actual);
            test_errors++;
        end
    endtask

    // board countdown never starts above its full length
    always @(negedge vsync) begin
        if (!reset) begin
            assert (time_grid[3] <= kitchen_pkg::chop_time) else begin
                $display("Fail %s: board timer expected at most %0d, actual %0d",
                         cur_test, kitchen_pkg::chop_time, time_grid[3]);
                test_errors++;
            end
        end
    end

    initial begin
        void'($urandom(92));
        vsync         = 1'b0;
        reset         = 1'b1;
        game_state    = kitchen_pkg::play;
        player0_state = kitchen_pkg::p_nothing;
        player1_state = kitchen_pkg::p_nothing;
        place_player(0, 1, 2, kitchen_pkg::left);   // facing the pantry
        place_player(1, 7, 4, kitchen_pkg::left);
        repeat (5) next_frame();
        reset = 1'b0;
        next_frame();

        start_test("reset_layout");
        for (int r = 0; r < kitchen_pkg::grid_rows; r++) begin
            for (int c = 0; c < kitchen_pkg::grid_cols; c++) begin
                check_cell(c, r, layout_at(c, r));
            end
        end
        check_timer(3, kitchen_pkg::chop_time);
        check_timer(2, kitchen_pkg::chop_time);
        check_timer(1, kitchen_pkg::cook_time);
        check_timer(0, kitchen_pkg::cook_time);
        finish_test();

        start_test("carry");
        player0_state = kitchen_pkg::p_onion_whole;
        next_frame();
        check_cell(0, 2, kitchen_pkg::obj_onion_whole);   // pantry refills
        place_player(0, 5, 4, kitchen_pkg::right);
        next_frame();
        player0_state = kitchen_pkg::p_nothing;
        next_frame();
        check_cell(6, 4, kitchen_pkg::obj_onion_whole);
        player1_state = kitchen_pkg::p_onion_whole;
        next_frame();
        check_cell(6, 4, kitchen_pkg::obj_empty);
        finish_test();

        start_test("chop");
        place_player(1, 1, 7, kitchen_pkg::right);   // player 1 drops its onion on board 2
        next_frame();
        player1_state = kitchen_pkg::p_nothing;
        next_frame();
        check_cell(2, 7, kitchen_pkg::obj_onion_whole);
        place_player(0, 2, 6, kitchen_pkg::down);
        next_frame();
        player0_state = kitchen_pkg::p_chopping;
        wait_for_cell(2, 7, kitchen_pkg::obj_onion_chopped,
                      kitchen_pkg::chop_time * kitchen_pkg::frames_per_tick + 20);
        check_timer(3, kitchen_pkg::chop_time);
        finish_test();

        start_test("cook_burn");
        player0_state = kitchen_pkg::p_nothing;
        next_frame();
        player0_state = kitchen_pkg::p_onion_chopped;
        next_frame();
        check_cell(2, 7, kitchen_pkg::obj_empty);
        place_player(0, 8, 1, kitchen_pkg::up);
        next_frame();
        player0_state = kitchen_pkg::p_nothing;
        next_frame();
        check_cell(8, 0, kitchen_pkg::obj_pot_raw);
        wait_for_cell(8, 0, kitchen_pkg::obj_pot_cooked,
                      kitchen_pkg::cook_time * kitchen_pkg::frames_per_tick + 20);
        wait_for_cell(8, 0, kitchen_pkg::obj_fire,
                      kitchen_pkg::burn_time * kitchen_pkg::frames_per_tick + 20);
        place_player(1, 7, 0, kitchen_pkg::right);
        next_frame();
        player1_state = kitchen_pkg::p_ext_on;
        next_frame();
        check_cell(8, 0, kitchen_pkg::obj_pot_empty);
        player1_state = kitchen_pkg::p_nothing;
        next_frame();
        finish_test();

        start_test("pause");
        place_player(0, 10, 1, kitchen_pkg::up);
        next_frame();
        player0_state = kitchen_pkg::p_pot_raw;
        next_frame();
        check_cell(10, 0, kitchen_pkg::obj_empty);
        player0_state = kitchen_pkg::p_nothing;
        next_frame();
        check_cell(10, 0, kitchen_pkg::obj_pot_raw);
        wait_for_timer_below(0, kitchen_pkg::cook_time, kitchen_pkg::frames_per_tick + 20);
        game_state = kitchen_pkg::pause;
        place_player(1, 5, 5, kitchen_pkg::right);
        next_frame();
        player1_state = kitchen_pkg::p_onion_whole;
        next_frame();
        player1_state = kitchen_pkg::p_nothing;   // put-down while paused
        repeat (3 * kitchen_pkg::frames_per_tick) begin
            next_frame();
            check_timer(0, kitchen_pkg::cook_time - 1);   // one tick in when paused
        end
        for (int r = 0; r < kitchen_pkg::grid_rows; r++) begin
            for (int c = 0; c < kitchen_pkg::grid_cols; c++) begin
                if (c == 10 && r == 0) begin
                    check_cell(c, r, kitchen_pkg::obj_pot_raw);
                end else begin
                    check_cell(c, r, layout_at(c, r));
                end
            end
        end
        finish_test();

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
hw/kitchen_pkg.sv
hw/player_if.sv
hw/player_locator.sv
hw/player_rules.sv
hw/countdown_timer.sv
hw/chop_station.sv
hw/pot_station.sv
hw/kitchen_grid.sv
hw/kitchen_action.sv
+incdir+test
test/tb_kitchen_action.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build with verilator, run, and judge the run from sim.log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_kitchen_action -o sim_kitchen > sim.log 2>&1 &&
./obj_dir/sim_kitchen >> sim.log 2>&1 &&
grep -q "^Test passed$" sim.log &&
{ echo "simulation passed"; exit 0; } ||
{ echo "simulation failed, see sim.log"; exit 1; }
